// ==== hdl/definitions.sv ====
package definitions;

    // basic widths
    typedef logic [31:0] instr_t;       // one RV32I instruction word
    typedef logic [4:0]  reg_name_t;    // register name, x0..x31
    typedef logic [6:0]  opcode_t;      // major opcode field, bits 6:0
    typedef logic [1:0]  credit_cnt_t;  // memory credits held by the port

    // RV32I major opcodes the control path cares about
    localparam opcode_t OP_LOAD   = 7'b0000011; // lb/lh/lw/lbu/lhu
    localparam opcode_t OP_STORE  = 7'b0100011; // sb/sh/sw
    localparam opcode_t OP_BRANCH = 7'b1100011; // beq/bne/blt/bge/...
    localparam opcode_t OP_JALR   = 7'b1100111; // jump to register
    localparam opcode_t OP_JAL    = 7'b1101111; // pc relative jump
    localparam opcode_t OP_OP     = 7'b0110011; // reg-reg alu
    localparam opcode_t OP_OPIMM  = 7'b0010011; // reg-imm alu
    localparam opcode_t OP_LUI    = 7'b0110111; // load upper immediate

    // one outstanding access by default
    localparam int MEM_CREDITS_DEFAULT = 1;

endpackage : definitions

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/100ps

module instr_decoder (
    input  logic                  clk,
    input  logic                  rstN,
    input  definitions::instr_t   instr_in,      // word from IF
    input  logic                  if_id_write,   // low holds the IF/ID register
    output definitions::reg_name_t rs1_id,
    output definitions::reg_name_t rs2_id,
    output definitions::reg_name_t rd_id,
    output logic                  branch_cu,     // conditional branch in ID
    output logic                  jump_reg_cu,   // jalr in ID
    output logic                  reg_write_id,
    output logic                  mem_read_id,
    output logic                  mem_write_id
);

    localparam definitions::instr_t NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

    definitions::instr_t  instr_q;  // IF/ID register
    definitions::opcode_t opcode;
    logic                 uses_rs1;
    logic                 uses_rs2;
    logic                 uses_rd;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            instr_q <= NOP_INSTR;          // empty pipe looks like a nop
        end else if (if_id_write) begin
            instr_q <= instr_in;
        end
    end

    assign opcode = instr_q[6:0];

    always_comb begin
        uses_rs1     = 1'b0;
        uses_rs2     = 1'b0;
        uses_rd      = 1'b0;
        branch_cu    = 1'b0;
        jump_reg_cu  = 1'b0;
        mem_read_id  = 1'b0;
        mem_write_id = 1'b0;
        case (opcode)
            definitions::OP_OP: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                uses_rd  = 1'b1;
            end
            definitions::OP_OPIMM: begin
                uses_rs1 = 1'b1;
                uses_rd  = 1'b1;
            end
            definitions::OP_LOAD: begin
                uses_rs1    = 1'b1;
                uses_rd     = 1'b1;
                mem_read_id = 1'b1;
            end
            definitions::OP_STORE: begin
                uses_rs1     = 1'b1;
                uses_rs2     = 1'b1;     // store data
                mem_write_id = 1'b1;
            end
            definitions::OP_BRANCH: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                branch_cu = 1'b1;
            end
            definitions::OP_JALR: begin
                uses_rs1    = 1'b1;
                uses_rd     = 1'b1;      // link register
                jump_reg_cu = 1'b1;
            end
            definitions::OP_JAL, definitions::OP_LUI: begin
                uses_rd = 1'b1;          // no source registers
            end
            default: ;                   // unknown opcode decodes as a bubble
        endcase
    end

    // unused fields read as x0 so they never match a writer
    assign rs1_id       = uses_rs1 ? instr_q[19:15] : '0;
    assign rs2_id       = uses_rs2 ? instr_q[24:20] : '0;
    assign rd_id        = uses_rd ? instr_q[11:7] : '0;
    assign reg_write_id = uses_rd;

endmodule : instr_decoder

// ==== hdl/id_ex_reg.sv ====
`timescale 1ns/100ps

module id_ex_reg (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   id_ex_enable,   // low loads a bubble
    input  logic                   reg_write_id,
    input  logic                   mem_read_id,
    input  logic                   mem_write_id,
    input  definitions::reg_name_t rd_id,
    output definitions::reg_name_t rd_ex,
    output logic                   reg_write_ex,
    output logic                   id_ex_mem_read,
    output logic                   id_ex_mem_write
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rd_ex           <= '0;    // start with a bubble in EX
            reg_write_ex    <= 1'b0;
            id_ex_mem_read  <= 1'b0;
            id_ex_mem_write <= 1'b0;
        end else if (id_ex_enable) begin
            rd_ex           <= rd_id; // advance ID into EX
            reg_write_ex    <= reg_write_id;
            id_ex_mem_read  <= mem_read_id;
            id_ex_mem_write <= mem_write_id;
        end else begin
            rd_ex           <= '0;    // stalled ID instr stays in ID only
            reg_write_ex    <= 1'b0;
            id_ex_mem_read  <= 1'b0;
            id_ex_mem_write <= 1'b0;
        end
    end

    // decoder gives one access kind per instr, bubbles give none
    a_one_mem_kind: assert property (
        @(posedge clk) disable iff (!rstN)
        !(id_ex_mem_read && id_ex_mem_write)
    ) else $error("load and store both flagged in EX");

endmodule : id_ex_reg

// ==== hdl/data_mem_port.sv ====
`timescale 1ns/100ps

module data_mem_port #(
    parameter int MEM_CREDITS = 1           // accesses the memory can accept
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   id_ex_mem_read,
    input  logic                   id_ex_mem_write,
    input  logic                   mem_credit_return, // one pulse per finished access
    input  definitions::reg_name_t rd_ex,
    output logic                   mem_req_valid,     // one cycle pulse per request
    output logic                   mem_req_write,     // 1 store, 0 load
    output logic                   mem_ready,         // low while an access is open
    output definitions::reg_name_t mem_req_rd         // destination tag
);

    logic                     mem_op_ex;     // load or store in EX
    logic                     capture;       // new access accepted this cycle
    logic                     issue;         // request goes out at this edge
    logic                     wait_q;        // accepted, waiting for a credit
    logic                     pend_write_q;  // held access kind
    definitions::reg_name_t   pend_rd_q;     // held destination tag
    definitions::credit_cnt_t credit_cnt;

    assign mem_op_ex = id_ex_mem_read | id_ex_mem_write;
    assign capture   = mem_op_ex & mem_ready;                  // one access at a time
    assign issue     = (capture | wait_q) & (credit_cnt != '0);

    always_ff @(posedge clk) begin
        if (capture) begin
            pend_write_q <= id_ex_mem_write;
            pend_rd_q    <= rd_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wait_q        <= 1'b0;
            mem_ready     <= 1'b1;
            mem_req_valid <= 1'b0;
            mem_req_write <= 1'b0;
            mem_req_rd    <= '0;
            credit_cnt    <= definitions::credit_cnt_t'(MEM_CREDITS);
        end else begin
            mem_req_valid <= issue;
            mem_req_write <= issue & (capture ? id_ex_mem_write : pend_write_q);
            mem_req_rd    <= issue ? (capture ? rd_ex : pend_rd_q) : '0;
            wait_q        <= (capture | wait_q) & ~issue; // no credit yet so keep waiting
            if (capture) begin
                mem_ready <= 1'b0;
            end else if (mem_credit_return && !mem_ready && !wait_q) begin
                mem_ready <= 1'b1;                        // our access came back
            end
            case ({mem_credit_return, issue})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;        // none or both cancel
            endcase
        end
    end

    a_credit_while_open: assert property (
        @(posedge clk) disable iff (!rstN)
        mem_credit_return |-> !mem_ready
    ) else $error("credit returned with no access open");

    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rstN)
        credit_cnt <= definitions::credit_cnt_t'(MEM_CREDITS)
    ) else $error("more credits returned than issued");

endmodule : data_mem_port

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/100ps

module hazard_unit (
    input  logic                   clk,
    input  logic                   rstN,
    input  definitions::reg_name_t rs1_id,
    input  definitions::reg_name_t rs2_id,
    input  definitions::reg_name_t rd_ex,
    input  logic                   branch_cu,
    input  logic                   jump_reg_cu,
    input  logic                   id_ex_mem_read,
    input  logic                   id_ex_mem_write,
    input  logic                   mem_ready,
    input  logic                   reg_write_ex,
    output logic                   if_id_write,
    output logic                   pc_write,
    output logic                   id_ex_enable,
    output logic                   pc_stall,
    output logic                   branch_hu,
    output logic                   jump_reg_hu
);

    typedef enum logic [2:0] {
        MEM_IDLE        = 3'd0,  // no access open
        MEM_PRE_READ    = 3'd1,  // load left EX but port not yet busy
        MEM_READ        = 3'd2,  // load in flight
        MEM_PRE_WRITE   = 3'd3,  // store left EX but port not yet busy
        MEM_WRITE       = 3'd4   // store in flight
    } mem_state_t;

    mem_state_t mem_state, mem_state_nxt;
    logic       ex_writes_rd;    // EX instr writes a real register
    logic       mem_stall;
    logic       branch_stall;
    logic       jump_reg_stall;
    logic       stall;

    assign ex_writes_rd   = reg_write_ex && (rd_ex != '0);
    assign mem_stall      = (mem_state != MEM_IDLE) | id_ex_mem_read | id_ex_mem_write;
    assign branch_stall   = branch_cu & ex_writes_rd & ((rs1_id == rd_ex) | (rs2_id == rd_ex));
    assign jump_reg_stall = jump_reg_cu & ex_writes_rd & (rs1_id == rd_ex); // rs1 only
    assign stall          = mem_stall | branch_stall | jump_reg_stall;

    assign branch_hu    = branch_cu & ~branch_stall;     // take branch once operands are safe
    assign jump_reg_hu  = jump_reg_cu & ~jump_reg_stall;
    assign pc_stall     = stall;
    assign pc_write     = ~stall;
    assign if_id_write  = ~stall;                        // hold ID instr
    assign id_ex_enable = ~stall;                        // bubble into EX

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mem_state <= MEM_IDLE;
        end else begin
            mem_state <= mem_state_nxt;
        end
    end

    always_comb begin
        mem_state_nxt = mem_state;
        case (mem_state)
            MEM_IDLE: begin
                if (id_ex_mem_read) begin
                    mem_state_nxt = MEM_PRE_READ;
                end else if (id_ex_mem_write) begin
                    mem_state_nxt = MEM_PRE_WRITE;
                end
            end
            MEM_PRE_READ: begin
                if (!mem_ready) mem_state_nxt = MEM_READ;      // port took the load
            end
            MEM_READ: begin
                if (mem_ready) mem_state_nxt = MEM_IDLE;       // data back
            end
            MEM_PRE_WRITE: begin
                if (!mem_ready) mem_state_nxt = MEM_WRITE;     // port took the store
            end
            MEM_WRITE: begin
                if (mem_ready) mem_state_nxt = MEM_IDLE;
            end
            default: mem_state_nxt = MEM_IDLE;                 // unused encodings
        endcase
    end

    a_hold_while_mem_open: assert property (
        @(posedge clk) disable iff (!rstN)
        !mem_ready |-> pc_stall
    ) else $error("pipeline advanced while a memory access was open");

endmodule : hazard_unit

// ==== hdl/pipe_ctrl_top.sv ====
`timescale 1ns/100ps

module pipe_ctrl_top #(
    parameter int MEM_CREDITS = definitions::MEM_CREDITS_DEFAULT
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  definitions::instr_t    instr_in,
    input  logic                   mem_credit_return,
    output logic                   pc_write,
    output logic                   pc_stall,
    output logic                   branch_hu,
    output logic                   jump_reg_hu,
    output logic                   mem_req_valid,
    output logic                   mem_req_write,
    output definitions::reg_name_t mem_req_rd
);

    definitions::reg_name_t rs1_id, rs2_id, rd_id;  // ID view
    definitions::reg_name_t rd_ex;                  // EX view
    logic branch_cu, jump_reg_cu;
    logic reg_write_id, mem_read_id, mem_write_id;
    logic reg_write_ex, id_ex_mem_read, id_ex_mem_write;
    logic if_id_write, id_ex_enable;
    logic mem_ready;

    instr_decoder i_instr_decoder (
        .clk, .rstN, .instr_in, .if_id_write,
        .rs1_id, .rs2_id, .rd_id,
        .branch_cu, .jump_reg_cu,
        .reg_write_id, .mem_read_id, .mem_write_id
    );

    id_ex_reg i_id_ex_reg (
        .clk, .rstN, .id_ex_enable,
        .reg_write_id, .mem_read_id, .mem_write_id, .rd_id,
        .rd_ex, .reg_write_ex, .id_ex_mem_read, .id_ex_mem_write
    );

    data_mem_port #(
        .MEM_CREDITS (MEM_CREDITS)
    ) i_data_mem_port (
        .clk, .rstN, .id_ex_mem_read, .id_ex_mem_write,
        .mem_credit_return, .rd_ex,
        .mem_req_valid, .mem_req_write, .mem_ready, .mem_req_rd
    );

    hazard_unit i_hazard_unit (
        .clk, .rstN, .rs1_id, .rs2_id, .rd_ex,
        .branch_cu, .jump_reg_cu, .id_ex_mem_read, .id_ex_mem_write,
        .mem_ready, .reg_write_ex,
        .if_id_write, .pc_write, .id_ex_enable, .pc_stall,
        .branch_hu, .jump_reg_hu
    );

endmodule : pipe_ctrl_top

// ==== testbench/tb_pipe_ctrl.sv ====
`timescale 1ns/100ps

module tb_pipe_ctrl;

    localparam string STIM_FILE = "testbench/pipe_ctrl_input.txt";
    localparam int    CLK_PERIOD = 10;

    logic                   clk;
    logic                   rstN;
    definitions::instr_t    instr_in;
    logic                   mem_credit_return;
    logic                   pc_write;
    logic                   pc_stall;
    logic                   branch_hu;
    logic                   jump_reg_hu;
    logic                   mem_req_valid;
    logic                   mem_req_write;
    definitions::reg_name_t mem_req_rd;

    // one entry per stimulus line
    definitions::instr_t    stim_instr[$];
    logic                   stim_credit[$];
    logic                   exp_stall[$];
    logic                   exp_branch[$];
    logic                   exp_jump[$];
    logic                   exp_valid[$];
    logic                   exp_write[$];
    definitions::reg_name_t exp_rd[$];
    int                     n_lines;
    logic                   loaded;

    pipe_ctrl_top #(
        .MEM_CREDITS (definitions::MEM_CREDITS_DEFAULT)
    ) i_pipe_ctrl_top (
        .clk, .rstN, .instr_in, .mem_credit_return,
        .pc_write, .pc_stall, .branch_hu, .jump_reg_hu,
        .mem_req_valid, .mem_req_write, .mem_req_rd
    );

    always #(CLK_PERIOD / 2) clk = ~clk;  // 10 ns clock

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1, "control output mismatch");
        end
    endtask

    task automatic check_reg(input string name, input definitions::reg_name_t got,
                             input definitions::reg_name_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is x%0d, expected x%0d", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1, "register tag mismatch");
        end
    endtask

    // reads the stimulus table, comment lines start with #
    task automatic load_stimulus();
        int    fd;
        int    n;
        string line;
        int    f_instr, f_cr, f_st, f_br, f_jr, f_val, f_wr, f_rd;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
            $display("Testbench failed");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;  // blank or comment
            n = $sscanf(line, "%h %d %d %d %d %d %d %h",
                        f_instr, f_cr, f_st, f_br, f_jr, f_val, f_wr, f_rd);
            if (n != 8) continue;                                       // malformed tail
            stim_instr.push_back(definitions::instr_t'(f_instr));
            stim_credit.push_back(f_cr[0]);
            exp_stall.push_back(f_st[0]);
            exp_branch.push_back(f_br[0]);
            exp_jump.push_back(f_jr[0]);
            exp_valid.push_back(f_val[0]);
            exp_write.push_back(f_wr[0]);
            exp_rd.push_back(definitions::reg_name_t'(f_rd));
        end
        $fclose(fd);
        n_lines = stim_instr.size();
    endtask

    initial begin
        clk               = 1'b0;
        rstN              = 1'b0;
        instr_in          = 32'h0000_0013;  // nop while in reset
        mem_credit_return = 1'b0;
        loaded            = 1'b0;
        n_lines           = 0;
        load_stimulus();
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        #1 rstN = 1'b1;
        for (int i = 0; i < n_lines; i++) begin
            instr_in          = stim_instr[i];     // applied 1 ns after the edge
            mem_credit_return = stim_credit[i];
            #(CLK_PERIOD - 2);                     // just before the next edge
            check_flag("pc_stall", pc_stall, exp_stall[i]);
            check_flag("pc_write", pc_write, !exp_stall[i]);
            check_flag("branch_hu", branch_hu, exp_branch[i]);
            check_flag("jump_reg_hu", jump_reg_hu, exp_jump[i]);
            check_flag("mem_req_valid", mem_req_valid, exp_valid[i]);
            check_flag("mem_req_write", mem_req_write, exp_write[i]);
            check_reg("mem_req_rd", mem_req_rd, exp_rd[i]);
            @(posedge clk);
            #1;
        end
        $display("Testbench passed");
        $finish;
    end

    // run length follows the table, plus reset and some slack
    initial begin
        wait (loaded);
        #((n_lines + 8 + 20) * CLK_PERIOD);
        $display("watchdog expired before the stimulus finished");
        $display("Testbench failed");
        $fatal(1, "timeout");
    end

endmodule : tb_pipe_ctrl

// ==== testbench/pipe_ctrl_input.txt ====
# instr_in credit_ret | exp: pc_stall branch_hu jump_reg_hu mem_req_valid mem_req_write mem_req_rd
# one line per cycle, outputs sampled just before the following clock edge
003100B3 0 0 0 0 0 0 00
00628233 0 0 0 0 0 0 00
003100B3 0 0 0 0 0 0 00
00208063 0 0 0 0 0 0 00
00310033 0 1 0 0 0 0 00
00310033 0 0 1 0 0 0 00
00208063 0 0 0 0 0 0 00
00208063 0 0 1 0 0 0 00
003100B3 0 0 1 0 0 0 00
00008067 0 0 0 0 0 0 00
00628233 0 1 0 0 0 0 00
00628233 0 0 0 1 0 0 00
003100B3 0 0 0 0 0 0 00
00128067 0 0 0 0 0 0 00
00012483 0 0 0 1 0 0 00
00628233 0 0 0 0 0 0 00
00208023 0 1 0 0 0 0 00
00208023 0 1 0 0 1 0 09
00208023 1 1 0 0 0 0 00
00208023 0 1 0 0 0 0 00
00208023 0 0 0 0 0 0 00
003100B3 0 0 0 0 0 0 00
00012503 0 1 0 0 0 0 00
00012503 0 1 0 0 1 1 00
00012503 1 1 0 0 0 0 00
00012503 0 1 0 0 0 0 00
00012503 0 0 0 0 0 0 00
00628233 0 0 0 0 0 0 00
00000013 0 1 0 0 0 0 00
00000013 0 1 0 0 1 0 0a
00000013 0 1 0 0 0 0 00
00000013 0 1 0 0 0 0 00
00000013 0 1 0 0 0 0 00
00000013 1 1 0 0 0 0 00
00000013 0 1 0 0 0 0 00
00000013 0 0 0 0 0 0 00

// ==== all.f ====
hdl/definitions.sv
hdl/instr_decoder.sv
hdl/id_ex_reg.sv
hdl/data_mem_port.sv
hdl/hazard_unit.sv
hdl/pipe_ctrl_top.sv
testbench/tb_pipe_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the pipeline-control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_pipe_ctrl \
    -o sim_pipe_ctrl

./obj_dir/sim_pipe_ctrl
